// ==== hdl/io_pkg.sv ====
//********************************************************************
// Widths, register map and debounce timing for the board I/O block
// DB_TICK should stay a power of two or larger than DB_SAMPLES
//********************************************************************

package io_pkg;

   // Bus and GPIO width
   localparam int DATA_W = 32;
   // Word address field, bus address bits 5 to 2
   localparam int ADR_W  = 4;

   localparam int BTN_W  = 5;
   localparam int SW_W   = 16;
   // Switch that selects the bot configuration
   localparam int CFG_SW = 15;

   //*****************************************************************
   // Register word offsets
   //*****************************************************************
   localparam logic [ADR_W-1:0] REG_IN   = 'd0;
   localparam logic [ADR_W-1:0] REG_OUT  = 'd1;
   localparam logic [ADR_W-1:0] REG_OE   = 'd2;
   localparam logic [ADR_W-1:0] REG_INTE = 'd3;
   localparam logic [ADR_W-1:0] REG_INTS = 'd4;

   //*****************************************************************
   // Debounce timing
   //*****************************************************************
   // Cycles between samples
   localparam int DB_TICK    = 16;
   // Equal samples needed before a new level is taken
   localparam int DB_SAMPLES = 4;
   localparam int DB_CNT_W   = $clog2(DB_TICK);
   localparam int DB_SMP_W   = $clog2(DB_SAMPLES + 1);

endpackage

// ==== hdl/wb_access_fsm.sv ====
//********************************************************************
// Single-access Wishbone slave handshake, ack one cycle after request
// Master must drop stb for a cycle after ack; no wait states
//********************************************************************

`timescale 1ns/1ns

module wb_access_fsm (
   input  logic clk,
   input  logic i_rst_n,
   input  logic i_cyc,
   input  logic i_stb,
   input  logic i_we,
   output logic o_ack,
   output logic o_wr_stb
);

   localparam logic ST_IDLE = 1'b0;
   localparam logic ST_ACK  = 1'b1;

   logic state_q;
   logic state_d;

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (i_cyc && i_stb) begin
               state_d = ST_ACK;
            end
         end
         ST_ACK: begin
            // Always back to idle, ack is a single pulse
            state_d = ST_IDLE;
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   assign o_ack = (state_q == ST_ACK);

   // Register write lands on the edge that closes the ack cycle
   assign o_wr_stb = (state_q == ST_ACK) && i_we;

endmodule

// ==== hdl/debounce_counter.sv ====
//********************************************************************
// Debounces buttons and switches by sampling every DB_TICK cycles
// Pulses shorter than DB_TICK cycles are never passed through
//********************************************************************

`timescale 1ns/1ns

module debounce_counter import io_pkg::*; (
   input  logic             clk,
   input  logic             i_rst_n,
   input  logic [BTN_W-1:0] i_btn,
   input  logic [SW_W-1:0]  i_sw,
   output logic [BTN_W-1:0] o_btn_db,
   output logic [SW_W-1:0]  o_sw_db
);

   localparam int IN_W = BTN_W + SW_W;

   logic [DB_CNT_W-1:0] tick_cnt_q;
   logic                tick;
   logic [IN_W-1:0]     sync_q;
   logic [IN_W-1:0]     db_q;
   logic [DB_SMP_W-1:0] smp_cnt_q [IN_W];

   // Sample tick timer
   assign tick = (tick_cnt_q == DB_CNT_W'(DB_TICK - 1));

   always_ff @(posedge clk) begin
      if (!i_rst_n || tick) begin
         tick_cnt_q <= '0;
      end else begin
         tick_cnt_q <= tick_cnt_q + 1'b1;
      end
   end

   // Raw inputs are asynchronous to clk
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         sync_q <= '0;
      end else begin
         sync_q <= {i_sw, i_btn};
      end
   end

   //*****************************************************************
   // Per-bit stability counters
   //*****************************************************************
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         db_q <= '0;
         for (int i = 0; i < IN_W; i++) begin
            smp_cnt_q[i] <= '0;
         end
      end else if (tick) begin
         for (int i = 0; i < IN_W; i++) begin
            if (sync_q[i] == db_q[i]) begin
               smp_cnt_q[i] <= '0;
            end else if (smp_cnt_q[i] == DB_SMP_W'(DB_SAMPLES - 1)) begin
               // Last of the required samples, accept new level
               db_q[i]      <= sync_q[i];
               smp_cnt_q[i] <= '0;
            end else begin
               smp_cnt_q[i] <= smp_cnt_q[i] + 1'b1;
            end
         end
      end
   end

   assign o_btn_db = db_q[BTN_W-1:0];
   assign o_sw_db  = db_q[IN_W-1:BTN_W];

endmodule

// ==== hdl/gpio_regs.sv ====
//********************************************************************
// GPIO register block: IN (read only), OUT, OE, INTE, INTS (W1C)
// Offsets 5 to 15 read zero and ignore writes
//********************************************************************

`timescale 1ns/1ns

module gpio_regs import io_pkg::*; (
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_wr_stb,
   input  logic [ADR_W-1:0]  i_adr,
   input  logic [DATA_W-1:0] i_dat,
   input  logic [BTN_W-1:0]  i_btn_db,
   input  logic [SW_W-1:0]   i_sw_db,
   output logic [DATA_W-1:0] o_rdt,
   output logic [DATA_W-1:0] o_pad_out,
   output logic [DATA_W-1:0] o_pad_oe,
   output logic              o_irq
);

   localparam int PAD_W = DATA_W - SW_W - BTN_W;

   logic [DATA_W-1:0] in_word;
   logic [DATA_W-1:0] in_q;
   logic [DATA_W-1:0] in_rise;
   logic [DATA_W-1:0] out_q;
   logic [DATA_W-1:0] oe_q;
   logic [DATA_W-1:0] inte_q;
   logic [DATA_W-1:0] ints_q;
   logic [DATA_W-1:0] ints_clr;
   logic              irq_q;

   // Buttons in 4:0, switches in 20:5
   assign in_word = {{PAD_W{1'b0}}, i_sw_db, i_btn_db};

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         in_q <= '0;
      end else begin
         in_q <= in_word;
      end
   end

   assign in_rise = in_word & ~in_q;

   //*****************************************************************
   // Control registers
   //*****************************************************************
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         out_q  <= '0;
         oe_q   <= '0;
         inte_q <= '0;
      end else if (i_wr_stb) begin
         case (i_adr)
            REG_OUT: begin
               out_q <= i_dat;
            end
            REG_OE: begin
               oe_q <= i_dat;
            end
            REG_INTE: begin
               inte_q <= i_dat;
            end
            default: begin
            end
         endcase
      end
   end

   // Write 1 to clear; a new edge in the same cycle wins
   assign ints_clr = (i_wr_stb && (i_adr == REG_INTS)) ? i_dat : '0;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         ints_q <= '0;
         irq_q  <= 1'b0;
      end else begin
         ints_q <= (ints_q & ~ints_clr) | (in_rise & inte_q);
         irq_q  <= |ints_q;
      end
   end

   //*****************************************************************
   // Read multiplexer
   //*****************************************************************
   always_comb begin
      case (i_adr)
         REG_IN: begin
            o_rdt = in_q;
         end
         REG_OUT: begin
            o_rdt = out_q;
         end
         REG_OE: begin
            o_rdt = oe_q;
         end
         REG_INTE: begin
            o_rdt = inte_q;
         end
         REG_INTS: begin
            o_rdt = ints_q;
         end
         default: begin
            o_rdt = '0;
         end
      endcase
   end

   assign o_pad_out = out_q;
   assign o_pad_oe  = oe_q;
   assign o_irq     = irq_q;

endmodule

// ==== hdl/io_top.sv ====
//********************************************************************
// Board I/O top: debounced buttons and switches behind a Wishbone GPIO
// Pads are split into out, oe and debounced inputs for simulation
//********************************************************************

`timescale 1ns/1ns

module io_top import io_pkg::*; (
   input  logic              clk,
   input  logic              i_rst_n,
   // Wishbone slave
   input  logic              i_wb_cyc,
   input  logic              i_wb_stb,
   input  logic              i_wb_we,
   input  logic [ADR_W-1:0]  i_wb_adr,
   input  logic [DATA_W-1:0] i_wb_dat,
   output logic [DATA_W-1:0] o_wb_rdt,
   output logic              o_wb_ack,
   // Board inputs
   input  logic [BTN_W-1:0]  i_btn,
   input  logic [SW_W-1:0]   i_sw,
   // Pads and status
   output logic [DATA_W-1:0] o_pad_out,
   output logic [DATA_W-1:0] o_pad_oe,
   output logic              o_irq,
   output logic              o_bot_config
);

   logic             wr_stb;
   logic [BTN_W-1:0] btn_db;
   logic [SW_W-1:0]  sw_db;

   wb_access_fsm wb_access_fsm_i (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_cyc    (i_wb_cyc),
      .i_stb    (i_wb_stb),
      .i_we     (i_wb_we),
      .o_ack    (o_wb_ack),
      .o_wr_stb (wr_stb)
   );

   debounce_counter debounce_counter_i (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_btn    (i_btn),
      .i_sw     (i_sw),
      .o_btn_db (btn_db),
      .o_sw_db  (sw_db)
   );

   // Address and data come straight from the bus, held until ack
   gpio_regs gpio_regs_i (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_wr_stb  (wr_stb),
      .i_adr     (i_wb_adr),
      .i_dat     (i_wb_dat),
      .i_btn_db  (btn_db),
      .i_sw_db   (sw_db),
      .o_rdt     (o_wb_rdt),
      .o_pad_out (o_pad_out),
      .o_pad_oe  (o_pad_oe),
      .o_irq     (o_irq)
   );

   assign o_bot_config = sw_db[CFG_SW];

endmodule

// ==== bench/io_checker.sv ====
//**********************************************************************
// Bus handshake and pad enable checks, bound into io_top
// All checks are off while reset is low
//**********************************************************************

`timescale 1ns/1ns

module io_checker import io_pkg::*; (
   input logic              clk,
   input logic              i_rst_n,
   input logic              i_cyc,
   input logic              i_stb,
   input logic              i_ack,
   input logic [DATA_W-1:0] i_pad_oe
);

   // Ack is a single pulse
   ack_single_cycle: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_ack |=> !i_ack)
      else $error("ack held high for two cycles");

   ack_after_request: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_ack |-> $past(i_cyc && i_stb))
      else $error("ack without cyc and stb in the cycle before");

   // OE only moves on the edge that ends a write ack
   oe_after_ack: assert property (@(posedge clk) disable iff (!i_rst_n)
      !$stable(i_pad_oe) |-> $past(i_ack))
      else $error("o_pad_oe changed outside the cycle after an ack");

endmodule

// ==== bench/tb_io_top.sv ====
//**********************************************************************
// Directed tests for io_top over Wishbone, inputs driven on falling edge
// Debounce bounds assume the package timing constants
//**********************************************************************

`timescale 1ns/1ns

module tb_io_top;
   import io_pkg::*;

   localparam int ACK_TIMEOUT  = 8;
   localparam int SETTLE_CYC   = DB_TICK * (DB_SAMPLES + 1) + 2;
   // One bus read plus the input register stage
   localparam int POLL_SLACK   = 4;
   localparam int GLITCH_WATCH = DB_TICK * (DB_SAMPLES + 2);

   logic              clk = 1'b0;
   logic              rst_n;
   logic              wb_cyc;
   logic              wb_stb;
   logic              wb_we;
   logic [ADR_W-1:0]  wb_adr;
   logic [DATA_W-1:0] wb_dat;
   logic [DATA_W-1:0] wb_rdt;
   logic              wb_ack;
   logic [BTN_W-1:0]  btn;
   logic [SW_W-1:0]   sw;
   logic [DATA_W-1:0] pad_out;
   logic [DATA_W-1:0] pad_oe;
   logic              irq;
   logic              bot_config;

   int          err_cnt = 0;
   int          timeout_cnt = 0;
   int          check_cnt = 0;
   int          cycle_cnt = 0;
   logic [31:0] rng_state = 32'h0f9b_d34a;

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   io_top io_top_i (
      .clk          (clk),
      .i_rst_n      (rst_n),
      .i_wb_cyc     (wb_cyc),
      .i_wb_stb     (wb_stb),
      .i_wb_we      (wb_we),
      .i_wb_adr     (wb_adr),
      .i_wb_dat     (wb_dat),
      .o_wb_rdt     (wb_rdt),
      .o_wb_ack     (wb_ack),
      .i_btn        (btn),
      .i_sw         (sw),
      .o_pad_out    (pad_out),
      .o_pad_oe     (pad_oe),
      .o_irq        (irq),
      .o_bot_config (bot_config)
   );

   bind io_top io_checker io_checker_i (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_cyc    (i_wb_cyc),
      .i_stb    (i_wb_stb),
      .i_ack    (o_wb_ack),
      .i_pad_oe (o_pad_oe)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Expected REG_IN layout, buttons low and switches above them
   function automatic logic [DATA_W-1:0] in_word_of(input logic [BTN_W-1:0] b,
                                                    input logic [SW_W-1:0] s);
      logic [DATA_W-1:0] w;
      w = '0;
      w[BTN_W-1:0] = b;
      w[BTN_W+SW_W-1:BTN_W] = s;
      return w;
   endfunction

   task automatic check_eq(input string what, input logic [DATA_W-1:0] got,
                           input logic [DATA_W-1:0] exp);
      check_cnt++;
      assert (got === exp) else begin
         err_cnt++;
         $display("** Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      end
   endtask

   //*******************************************************************
   // Bus tasks, each starts and ends on a falling edge
   //*******************************************************************
   task automatic wb_write(input logic [ADR_W-1:0] adr, input logic [DATA_W-1:0] dat);
      int cycles;
      cycles = 0;
      @(negedge clk);
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = 1'b1;
      wb_adr = adr;
      wb_dat = dat;
      @(negedge clk);
      while (!wb_ack && cycles < ACK_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (!wb_ack) begin
         timeout_cnt++;
         $display("Timeout: write to offset %0d got no ack within %0d cycles", adr, ACK_TIMEOUT);
      end
      // Hold through the edge that ends the ack cycle
      @(negedge clk);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_read(input logic [ADR_W-1:0] adr, output logic [DATA_W-1:0] rdt);
      int cycles;
      cycles = 0;
      @(negedge clk);
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = 1'b0;
      wb_adr = adr;
      @(negedge clk);
      while (!wb_ack && cycles < ACK_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (!wb_ack) begin
         timeout_cnt++;
         $display("Timeout: read from offset %0d got no ack within %0d cycles", adr, ACK_TIMEOUT);
      end
      rdt = wb_rdt;
      @(negedge clk);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
   endtask

   // Poll REG_IN until it matches or the debounce bound runs out
   task automatic wait_for_in_word(input logic [DATA_W-1:0] exp, input string what);
      int                start_cyc;
      logic [DATA_W-1:0] rdt;
      start_cyc = cycle_cnt;
      wb_read(REG_IN, rdt);
      while (rdt !== exp && (cycle_cnt - start_cyc) <= SETTLE_CYC + POLL_SLACK) begin
         wb_read(REG_IN, rdt);
      end
      check_eq(what, rdt, exp);
   endtask

   //*******************************************************************
   // Directed tests
   //*******************************************************************
   task automatic test_reset_values();
      logic [DATA_W-1:0] rdt;
      wb_read(REG_OUT, rdt);
      check_eq("OUT after reset", rdt, '0);
      wb_read(REG_OE, rdt);
      check_eq("OE after reset", rdt, '0);
      wb_read(REG_INTE, rdt);
      check_eq("INTE after reset", rdt, '0);
      wb_read(REG_INTS, rdt);
      check_eq("INTS after reset", rdt, '0);
      check_eq("o_irq after reset", DATA_W'(irq), '0);
      check_eq("o_pad_oe after reset", pad_oe, '0);
   endtask

   task automatic test_register_access();
      logic [DATA_W-1:0] out_val;
      logic [DATA_W-1:0] oe_val;
      logic [DATA_W-1:0] rdt;
      rng_state = xorshift(rng_state);
      out_val = rng_state;
      rng_state = xorshift(rng_state);
      oe_val = rng_state;
      wb_write(REG_OUT, out_val);
      wb_write(REG_OE, oe_val);
      check_eq("o_pad_out", pad_out, out_val);
      check_eq("o_pad_oe", pad_oe, oe_val);
      wb_read(REG_OUT, rdt);
      check_eq("OUT readback", rdt, out_val);
      wb_read(REG_OE, rdt);
      check_eq("OE readback", rdt, oe_val);
      rng_state = xorshift(rng_state);
      wb_write(ADR_W'(9), rng_state);
      wb_read(ADR_W'(9), rdt);
      check_eq("offset 9 read", rdt, '0);
   endtask

   task automatic test_debounce_accept();
      for (int n = 0; n < 2; n++) begin
         rng_state = xorshift(rng_state);
         @(negedge clk);
         btn = rng_state[BTN_W-1:0];
         sw  = rng_state[BTN_W+SW_W-1:BTN_W];
         wait_for_in_word(in_word_of(btn, sw), "REG_IN after settle");
         check_eq("o_bot_config", DATA_W'(bot_config), DATA_W'(sw[CFG_SW]));
      end
   endtask

   task automatic test_glitch_reject();
      int                start_cyc;
      logic [DATA_W-1:0] rdt;
      @(negedge clk);
      btn = '0;
      sw  = '0;
      wait_for_in_word('0, "REG_IN before glitch");
      @(negedge clk);
      start_cyc = cycle_cnt;
      // REG_IN is watched from the start of the pulse
      fork
         begin
            btn[1] = 1'b1;
            repeat (DB_TICK - 2) @(negedge clk);
            btn[1] = 1'b0;
         end
      join_none
      while ((cycle_cnt - start_cyc) < GLITCH_WATCH) begin
         wb_read(REG_IN, rdt);
         check_eq("REG_IN during and after short pulse", rdt, '0);
      end
   endtask

   task automatic test_interrupt();
      int                cycles;
      logic [DATA_W-1:0] rdt;
      wb_write(REG_INTE, 32'h1);
      @(negedge clk);
      btn[0] = 1'b1;
      cycles = 0;
      while (!irq && cycles < SETTLE_CYC + POLL_SLACK) begin
         @(negedge clk);
         cycles++;
      end
      check_eq("o_irq after press", DATA_W'(irq), 32'h1);
      wb_read(REG_INTS, rdt);
      check_eq("INTS after press", rdt, 32'h1);
      wb_write(REG_INTS, 32'h1);
      wb_read(REG_INTS, rdt);
      check_eq("INTS after clear", rdt, '0);
      check_eq("o_irq after clear", DATA_W'(irq), '0);
      // Second press with the interrupt disabled
      wb_write(REG_INTE, '0);
      @(negedge clk);
      btn[0] = 1'b0;
      wait_for_in_word('0, "REG_IN after release");
      @(negedge clk);
      btn[0] = 1'b1;
      wait_for_in_word(32'h1, "REG_IN after second press");
      wb_read(REG_INTS, rdt);
      check_eq("INTS with INTE clear", rdt, '0);
      check_eq("o_irq with INTE clear", DATA_W'(irq), '0);
   endtask

   initial begin
      rst_n  = 1'b0;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      wb_adr = '0;
      wb_dat = '0;
      btn    = '0;
      sw     = '0;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      test_reset_values();
      test_register_access();
      test_debounce_accept();
      test_glitch_reject();
      test_interrupt();
      $display("Checks: %0d, errors: %0d, timeouts: %0d", check_cnt, err_cnt, timeout_cnt);
      if (err_cnt == 0 && timeout_cnt == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
hdl/io_pkg.sv
hdl/wb_access_fsm.sv
hdl/debounce_counter.sv
hdl/gpio_regs.sv
hdl/io_top.sv
bench/io_checker.sv
bench/tb_io_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the io_top testbench with Verilator.
# Exit status is 0 on pass, 1 on any failure.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_tb_io_top
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
   --top-module tb_io_top -Mdir "$BUILD_DIR" -o "$SIM_BIN" -f vlog.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q -F '*** FAILED ***' "$LOG"; then
   echo "Testbench reported failure, see $LOG"
   exit 1
fi

if ! grep -q -F '*** PASSED ***' "$LOG"; then
   echo "Testbench did not finish, see $LOG"
   exit 1
fi

echo "Simulation passed"
exit 0
